//--- include/spi_reg_ctrl_settings.svh
`ifndef SPI_REG_CTRL_SETTINGS_SVH
`define SPI_REG_CTRL_SETTINGS_SVH

// register frame length in bits
// high byte is the address, low byte the value
`define SPI_FRAME_BITS 16

// control register addresses
`define SPI_ADDR_LED 8'd7
`define SPI_ADDR_MUX 8'd8
`define SPI_ADDR_DAC 8'd9

// routed peripherals
// index 0 is the ADC, index 1 the DAC
// mux code for index i is i + 1
`define SPI_N_PERIPH 2

// flops in the pin synchronizer
// end-to-end register latency grows with this
`define SPI_SYNC_STAGES 2

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_spi_reg_ctrl \
  -f spi_reg_ctrl.f \
  -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "run_sim: verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_spi_reg_ctrl)
sim_rc=$?
printf '%s\n' "$sim_out"
if [ $sim_rc -ne 0 ]; then
  echo "run_sim: simulation exited with status $sim_rc"
  exit 1
fi

if grep -qx "Simulation PASSED" <<< "$sim_out"; then
  exit 0
else
  echo "run_sim: pass message not found"
  exit 1
fi

//--- sim/spi_stimulus.txt
# kind(0 reg, 1 passthrough) bits word(hex) led1led2(bin) dac(hex) frame_err dest
# dest: 0 no peripheral, 1 ADC, 2 DAC; led, dac and frame_err are the state after the line
0 16 0703 11 0 0 0
0 16 0701 01 0 0 0
0 16 090A 01 A 0 0
0 16 09F5 01 5 0 0
0 15 0702 01 5 1 0
0 17 10702 01 5 1 0
0 16 2203 01 5 0 0
1 16 A5C3 01 5 0 0
0 16 0801 01 5 0 0
1 16 A5C3 01 5 0 1
1 8 3C 01 5 0 1
0 16 0700 00 5 0 0
0 16 0802 00 5 0 0
1 16 1234 00 5 0 2
1 11 5A3 00 5 0 2
0 16 0900 00 0 0 0
0 16 0800 00 0 0 0
1 12 0ABC 00 0 0 0
0 16 0702 10 0 0 0

//--- sim/tb_spi_reg_ctrl.sv
`timescale 1ns/1ps
`include "spi_reg_ctrl_settings.svh"

module tb_spi_reg_ctrl;
  import spi_reg_ctrl_pkg::*;

  localparam int clk_half  = 20;
  localparam int sclk_half = 4;
  localparam int max_lines = 64;

  logic                     cs;
  logic                     rst_n;
  spi_pins_t                pins;
  logic                     frame_err;
  logic [`SPI_N_PERIPH-1:0] periph_cs_n;
  logic [`SPI_N_PERIPH-1:0] periph_sclk;
  logic [`SPI_N_PERIPH-1:0] periph_sdi;
  logic                     led1;
  logic                     led2;
  logic                     dac_ldac;
  logic                     dac_rst;
  logic                     dac_uni_bip_a;
  logic                     dac_uni_bip_b;

  // one row per transfer from the stimulus file
  int          t_kind [max_lines];
  int          t_bits [max_lines];
  logic [31:0] t_word [max_lines];
  logic [1:0]  t_led  [max_lines];
  logic [3:0]  t_dac  [max_lines];
  int          t_err  [max_lines];
  int          t_dest [max_lines];
  int          n_lines;
  logic        loaded;
  int          err_cnt;
  int          chk_cnt;
  logic [15:0] lfsr;

  // what the monitor saw since the last cs_n fall on the pins
  logic [31:0]              cap [`SPI_N_PERIPH];
  logic [`SPI_N_PERIPH-1:0] seen_low;
  logic [`SPI_N_PERIPH-1:0] sclk_prev;
  logic                     pin_cs_prev;
  logic                     err_seen;

  spi_reg_ctrl_top u_dut (
    .cs            (cs),
    .rst_n         (rst_n),
    .pins          (pins),
    .frame_err     (frame_err),
    .periph_cs_n   (periph_cs_n),
    .periph_sclk   (periph_sclk),
    .periph_sdi    (periph_sdi),
    .led1          (led1),
    .led2          (led2),
    .dac_ldac      (dac_ldac),
    .dac_rst       (dac_rst),
    .dac_uni_bip_a (dac_uni_bip_a),
    .dac_uni_bip_b (dac_uni_bip_b)
  );

  initial
  begin
    cs = 1'b0;
    forever #(clk_half) cs = ~cs;
  end

  // sampled on the falling edge, away from output updates
  always @(negedge cs)
  begin
    if (!rst_n || (!pins.cs_n && pin_cs_prev))
    begin
      seen_low = '0;
      err_seen = 1'b0;
      for (int p = 0; p < `SPI_N_PERIPH; p++)
        cap[p] = '0;
    end
    for (int p = 0; p < `SPI_N_PERIPH; p++)
    begin
      if (!periph_cs_n[p])
      begin
        seen_low[p] = 1'b1;
        // mode 0, data valid at sclk rise
        if (periph_sclk[p] && !sclk_prev[p])
          cap[p] = {cap[p][30:0], periph_sdi[p]};
      end
    end
    sclk_prev = periph_sclk;
    if (frame_err)
      err_seen = 1'b1;
    pin_cs_prev = pins.cs_n;
  end

  // galois form, taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // 3 random bits, one step each
  task automatic random_gap(output int gap);
    gap = 0;
    for (int i = 0; i < 3; i++)
    begin
      gap = (gap << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // ends 2 ns after a rising edge, where inputs change
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge cs);
    #2;
  endtask

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    chk_cnt++;
    assert (got == exp)
    else
    begin
      err_cnt++;
      $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic load_stimulus();
    int          fd;
    int          r;
    string       line;
    int          kind;
    int          bits;
    logic [31:0] word;
    logic [1:0]  led;
    logic [3:0]  dac;
    int          err;
    int          dest;
    fd = $fopen("sim/spi_stimulus.txt", "r");
    if (fd == 0)
      $display("could not open sim/spi_stimulus.txt for reading");
    else
    begin
      while (!$feof(fd) && n_lines < max_lines)
      begin
        r = $fgets(line, fd);
        // header lines fail to parse and are skipped
        if (r > 0 && $sscanf(line, "%d %d %h %b %h %d %d",
                             kind, bits, word, led, dac, err, dest) == 7)
        begin
          t_kind[n_lines] = kind;
          t_bits[n_lines] = bits;
          t_word[n_lines] = word;
          t_led[n_lines]  = led;
          t_dac[n_lines]  = dac;
          t_err[n_lines]  = err;
          t_dest[n_lines] = dest;
          n_lines++;
        end
      end
      $fclose(fd);
    end
  endtask

  // bit-bang one transfer, msb first, sclk half period of 4 clocks
  task automatic send_transfer(input int kind, input int nbits, input logic [31:0] word);
    pins.special = (kind == 1);
    wait_cycles(2);
    pins.cs_n = 1'b0;
    wait_cycles(sclk_half);
    for (int i = nbits - 1; i >= 0; i--)
    begin
      pins.mosi = word[i];
      wait_cycles(sclk_half);
      pins.sclk = 1'b1;
      wait_cycles(sclk_half);
      pins.sclk = 1'b0;
    end
    wait_cycles(sclk_half);
    pins.cs_n = 1'b1;
    pins.mosi = 1'b0;
    wait_cycles(2);
    pins.special = 1'b0;
  endtask

  task automatic check_transfer(input int idx);
    logic [31:0] mask;
    logic        exp_low;
    mask = (t_bits[idx] >= 32) ? 32'hFFFF_FFFF : ((32'h1 << t_bits[idx]) - 32'h1);
    check_val(32'({led1, led2}), 32'(t_led[idx]), $sformatf("line %0d led pins", idx));
    check_val(32'({dac_ldac, dac_rst, dac_uni_bip_a, dac_uni_bip_b}), 32'(t_dac[idx]),
              $sformatf("line %0d dac pins", idx));
    check_val(32'(err_seen), 32'(t_err[idx]), $sformatf("line %0d frame_err pulse", idx));
    for (int p = 0; p < `SPI_N_PERIPH; p++)
    begin
      // dest counts from 1, index from 0
      exp_low = (t_dest[idx] == p + 1);
      check_val(32'(seen_low[p]), 32'(exp_low), $sformatf("line %0d periph %0d cs_n low", idx, p));
      if (exp_low)
        check_val(cap[p] & mask, t_word[idx] & mask,
                  $sformatf("line %0d periph %0d captured word", idx, p));
    end
  endtask

  // limit scales with the number of transfers
  initial
  begin
    int limit;
    wait (loaded === 1'b1);
    limit = n_lines * 400 + 1000;
    #(limit * 2 * clk_half);
    $display("timeout: run not finished after %0d clock cycles", limit);
    $display("Simulation FAILED");
    $finish;
  end

  initial
  begin
    int gap;
    pins    = '{sclk: 1'b0, mosi: 1'b0, cs_n: 1'b1, special: 1'b0};
    rst_n   = 1'b0;
    err_cnt = 0;
    chk_cnt = 0;
    n_lines = 0;
    loaded  = 1'b0;
    lfsr    = 16'd971;
    load_stimulus();
    loaded = 1'b1;
    if (n_lines == 0)
    begin
      $display("no transfers read from sim/spi_stimulus.txt");
      $display("Simulation FAILED");
    end
    else
    begin
      repeat (8) @(posedge cs);
      #2;
      rst_n = 1'b1;
      wait_cycles(2);
      // reset state of every pin
      check_val(32'(periph_cs_n), 32'({`SPI_N_PERIPH{1'b1}}), "periph_cs_n after reset");
      check_val(32'({led1, led2}), 32'h0, "led pins after reset");
      check_val(32'({dac_ldac, dac_rst, dac_uni_bip_a, dac_uni_bip_b}), 32'h0,
                "dac pins after reset");
      check_val(32'(frame_err), 32'h0, "frame_err after reset");
      for (int idx = 0; idx < n_lines; idx++)
      begin
        send_transfer(t_kind[idx], t_bits[idx], t_word[idx]);
        // register latency is 5 cycles, gap is at least 10
        random_gap(gap);
        wait_cycles(10 + gap);
        check_transfer(idx);
      end
      $display("transfers: %0d  checks: %0d  errors: %0d", n_lines, chk_cnt, err_cnt);
      if (err_cnt == 0)
        $display("Simulation PASSED");
      else
        $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- spi_reg_ctrl.f
+incdir+include
src/spi_reg_ctrl_pkg.sv
src/spi_frame_rx.sv
src/spi_reg_bank.sv
src/periph_cs_gate.sv
src/periph_bus_out.sv
src/spi_reg_ctrl_top.sv
sim/tb_spi_reg_ctrl.sv

//--- src/periph_bus_out.sv
`timescale 1ns/1ps
`include "spi_reg_ctrl_settings.svh"

module periph_bus_out (
  input  logic                         cs,
  input  logic                         rst_n,
  input  spi_reg_ctrl_pkg::spi_pins_t  sync,
  input  logic [`SPI_N_PERIPH-1:0]     selected,
  input  logic [`SPI_N_PERIPH-1:0]     sel_cs_n,
  input  spi_reg_ctrl_pkg::ctrl_regs_t regs,
  output logic [`SPI_N_PERIPH-1:0]     periph_cs_n,
  output logic [`SPI_N_PERIPH-1:0]     periph_sclk,
  output logic [`SPI_N_PERIPH-1:0]     periph_sdi,
  output logic                         led1,
  output logic                         led2,
  output logic                         dac_ldac,
  output logic                         dac_rst,
  output logic                         dac_uni_bip_a,
  output logic                         dac_uni_bip_b
);

  logic [`SPI_N_PERIPH-1:0] window;

  // routed here and its select is active
  assign window = selected & ~sel_cs_n;

  // every pin from a flop, no decode glitches
  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      periph_cs_n   <= '1;
      periph_sclk   <= '0;
      periph_sdi    <= '0;
      led1          <= 1'b0;
      led2          <= 1'b0;
      dac_ldac      <= 1'b0;
      dac_rst       <= 1'b0;
      dac_uni_bip_a <= 1'b0;
      dac_uni_bip_b <= 1'b0;
    end
    else
    begin
      periph_cs_n <= sel_cs_n;
      // clock and data stay low outside the window
      periph_sclk <= window & {`SPI_N_PERIPH{sync.sclk}};
      periph_sdi  <= window & {`SPI_N_PERIPH{sync.mosi}};
      led1          <= regs.led.led1;
      led2          <= regs.led.led2;
      dac_ldac      <= regs.dac.ldac;
      dac_rst       <= regs.dac.rst;
      dac_uni_bip_a <= regs.dac.uni_bip_a;
      dac_uni_bip_b <= regs.dac.uni_bip_b;
    end
  end

  // gates must never select two peripherals at once
  a_one_hot_cs : assert property (@(posedge cs) disable iff (!rst_n)
    $countones(~periph_cs_n) <= 1);

endmodule

//--- src/periph_cs_gate.sv
`timescale 1ns/1ps

module periph_cs_gate #(
  // mux code that routes the bus to this peripheral
  parameter logic [7:0] periph_code = 8'd1
) (
  input  logic                        cs,
  input  logic                        rst_n,
  input  logic [7:0]                  mux_code,
  input  spi_reg_ctrl_pkg::spi_pins_t sync,
  output logic                        selected,
  output logic                        cs_n_out
);

  logic pending_q;
  logic active_q;

  // pending follows the mux register at any time
  // active only moves while the bus is idle
  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      pending_q <= 1'b0;
      active_q  <= 1'b0;
    end
    else
    begin
      pending_q <= (mux_code == periph_code);
      // no switch inside a chip-select window
      if (sync.cs_n)
        active_q <= pending_q;
    end
  end

  assign selected = active_q;

  // passthrough window only when routed here and special is high
  // otherwise hold this peripheral deselected
  assign cs_n_out = (active_q && sync.special) ? sync.cs_n : 1'b1;

  // a peripheral never sees its select appear or vanish mid-transfer
  a_sel_stable : assert property (@(posedge cs) disable iff (!rst_n)
    !sync.cs_n && $past(!sync.cs_n) && $stable(sync.special) |-> $stable(cs_n_out));

endmodule

//--- src/spi_frame_rx.sv
`timescale 1ns/1ps
`include "spi_reg_ctrl_settings.svh"

module spi_frame_rx (
  input  logic                         cs,
  input  logic                         rst_n,
  input  spi_reg_ctrl_pkg::spi_pins_t  pins,
  output spi_reg_ctrl_pkg::spi_pins_t  sync,
  output spi_reg_ctrl_pkg::spi_frame_t frame,
  output logic                         frame_valid,
  output logic                         frame_err
);
  import spi_reg_ctrl_pkg::*;

  // counter saturates one past the frame length
  localparam int cnt_w = $clog2(`SPI_FRAME_BITS + 2);
  localparam logic [cnt_w-1:0] frame_len = cnt_w'(`SPI_FRAME_BITS);
  localparam logic [cnt_w-1:0] cnt_max = cnt_w'(`SPI_FRAME_BITS + 1);

  // idle bus with chip select high and clock low
  localparam spi_pins_t pins_idle = '{sclk: 1'b0, mosi: 1'b0, cs_n: 1'b1, special: 1'b0};

  spi_pins_t                  sync_q [`SPI_SYNC_STAGES];
  spi_pins_t                  sync_d;
  logic [`SPI_FRAME_BITS-1:0] shift_q;
  logic [cnt_w-1:0]           bit_cnt;
  logic                       sclk_rise;
  logic                       cs_rise;
  logic                       cs_fall;
  logic                       take_bit;

  // pin synchronizer plus one extra stage for edge detect
  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `SPI_SYNC_STAGES; i++)
        sync_q[i] <= pins_idle;
      sync_d <= pins_idle;
    end
    else
    begin
      sync_q[0] <= pins;
      for (int i = 1; i < `SPI_SYNC_STAGES; i++)
        sync_q[i] <= sync_q[i-1];
      sync_d <= sync_q[`SPI_SYNC_STAGES-1];
    end
  end

  assign sync = sync_q[`SPI_SYNC_STAGES-1];

  // edges on the synchronized pins
  assign sclk_rise = sync.sclk & ~sync_d.sclk;
  assign cs_rise   = sync.cs_n & ~sync_d.cs_n;
  assign cs_fall   = ~sync.cs_n & sync_d.cs_n;

  // mode 0 sampling on sclk rise for register frames only
  assign take_bit = sclk_rise & ~sync.cs_n & ~sync.special;

  // msb first
  always_ff @(posedge cs)
  begin
    if (take_bit)
      shift_q <= {shift_q[`SPI_FRAME_BITS-2:0], sync.mosi};
  end

  always_ff @(posedge cs)
  begin
    if (!rst_n)
      bit_cnt <= '0;
    else if (cs_fall)
      bit_cnt <= '0;
    else if (take_bit && bit_cnt != cnt_max)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // length check at the end of the frame
  // zero bits means passthrough or an empty select and is no error
  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      frame_valid <= 1'b0;
      frame_err   <= 1'b0;
    end
    else
    begin
      frame_valid <= cs_rise && (bit_cnt == frame_len);
      frame_err   <= cs_rise && (bit_cnt != frame_len) && (bit_cnt != '0);
    end
  end

  // word is stable once cs_n is high again
  assign frame = spi_frame_t'(shift_q);

  // one single-cycle strobe per frame end
  a_strobe_single : assert property (@(posedge cs) disable iff (!rst_n)
    (frame_valid || frame_err) |=> !(frame_valid || frame_err));

endmodule

//--- src/spi_reg_bank.sv
`timescale 1ns/1ps
`include "spi_reg_ctrl_settings.svh"

module spi_reg_bank (
  input  logic                         cs,
  input  logic                         rst_n,
  input  spi_reg_ctrl_pkg::spi_frame_t frame,
  input  logic                         frame_valid,
  output spi_reg_ctrl_pkg::ctrl_regs_t regs
);
  import spi_reg_ctrl_pkg::*;

  reg_value_u value;

  // same byte, read through the view the address picks
  assign value = frame.value;

  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      // mux to none, LEDs off, DAC pins low
      regs <= '0;
    end
    else if (frame_valid)
    begin
      case (frame.addr)
        `SPI_ADDR_MUX:
        begin
          // raw code, decoded later by each gate
          regs.mux_code <= value.mux_code;
        end
        `SPI_ADDR_LED:
        begin
          regs.led.rsvd <= '0;
          regs.led.led1 <= value.led.led1;
          regs.led.led2 <= value.led.led2;
        end
        `SPI_ADDR_DAC:
        begin
          // upper nibble not wired to anything
          regs.dac.rsvd      <= '0;
          regs.dac.ldac      <= value.dac.ldac;
          regs.dac.rst       <= value.dac.rst;
          regs.dac.uni_bip_a <= value.dac.uni_bip_a;
          regs.dac.uni_bip_b <= value.dac.uni_bip_b;
        end
        default:
        begin
          // unknown address, nothing changes
          regs <= regs;
        end
      endcase
    end
  end

  // registers move only on the cycle after a checked frame
  a_regs_on_frame : assert property (@(posedge cs) disable iff (!rst_n)
    !$stable(regs) |-> $past(frame_valid));

endmodule

//--- src/spi_reg_ctrl_pkg.sv
package spi_reg_ctrl_pkg;

  // raw or synchronized SPI pins
  typedef struct packed {
    logic sclk;
    logic mosi;
    logic cs_n;
    // high selects passthrough, low a register frame
    logic special;
  } spi_pins_t;

  // LED register, bit 1 is led1, bit 0 is led2
  typedef struct packed {
    logic [5:0] rsvd;
    logic       led1;
    logic       led2;
  } led_ctrl_t;

  // DAC control pins, low nibble only
  typedef struct packed {
    logic [3:0] rsvd;
    logic       ldac;
    logic       rst;
    logic       uni_bip_a;
    logic       uni_bip_b;
  } dac_ctrl_t;

  // one value byte, view picked by the frame address
  typedef union packed {
    // 1 = ADC, 2 = DAC, other = none
    logic [7:0] mux_code;
    led_ctrl_t  led;
    dac_ctrl_t  dac;
  } reg_value_u;

  typedef struct packed {
    logic [7:0] addr;
    reg_value_u value;
  } spi_frame_t;

  typedef struct packed {
    logic [7:0] mux_code;
    led_ctrl_t  led;
    dac_ctrl_t  dac;
  } ctrl_regs_t;

endpackage

//--- src/spi_reg_ctrl_top.sv
`timescale 1ns/1ps
`include "spi_reg_ctrl_settings.svh"

module spi_reg_ctrl_top (
  input  logic                        cs,
  input  logic                        rst_n,
  input  spi_reg_ctrl_pkg::spi_pins_t pins,
  output logic                        frame_err,
  output logic [`SPI_N_PERIPH-1:0]    periph_cs_n,
  output logic [`SPI_N_PERIPH-1:0]    periph_sclk,
  output logic [`SPI_N_PERIPH-1:0]    periph_sdi,
  output logic                        led1,
  output logic                        led2,
  output logic                        dac_ldac,
  output logic                        dac_rst,
  output logic                        dac_uni_bip_a,
  output logic                        dac_uni_bip_b
);
  import spi_reg_ctrl_pkg::*;

  spi_pins_t                sync;
  spi_frame_t               frame;
  logic                     frame_valid;
  ctrl_regs_t               regs;
  logic [`SPI_N_PERIPH-1:0] sel_cs_n;
  logic [`SPI_N_PERIPH-1:0] selected;

  // pins in, checked frames out
  spi_frame_rx u_frame_rx (
    .cs          (cs),
    .rst_n       (rst_n),
    .pins        (pins),
    .sync        (sync),
    .frame       (frame),
    .frame_valid (frame_valid),
    .frame_err   (frame_err)
  );

  spi_reg_bank u_reg_bank (
    .cs          (cs),
    .rst_n       (rst_n),
    .frame       (frame),
    .frame_valid (frame_valid),
    .regs        (regs)
  );

  // one gate per peripheral, code 1 is ADC, code 2 is DAC
  for (genvar g = 0; g < `SPI_N_PERIPH; g++)
  begin : g_gate
    periph_cs_gate #(
      .periph_code (8'(g + 1))
    ) u_gate (
      .cs       (cs),
      .rst_n    (rst_n),
      .mux_code (regs.mux_code),
      .sync     (sync),
      .selected (selected[g]),
      .cs_n_out (sel_cs_n[g])
    );
  end

  periph_bus_out u_bus_out (
    .cs            (cs),
    .rst_n         (rst_n),
    .sync          (sync),
    .selected      (selected),
    .sel_cs_n      (sel_cs_n),
    .regs          (regs),
    .periph_cs_n   (periph_cs_n),
    .periph_sclk   (periph_sclk),
    .periph_sdi    (periph_sdi),
    .led1          (led1),
    .led2          (led2),
    .dac_ldac      (dac_ldac),
    .dac_rst       (dac_rst),
    .dac_uni_bip_a (dac_uni_bip_a),
    .dac_uni_bip_b (dac_uni_bip_b)
  );

endmodule
